//--- tb.f
+incdir+.
core_pkg.sv
fetch_unit.sv
cache.sv
arbiter.sv
memory_controller.sv
core_top.sv
tb_core.sv

//--- Makefile
SIM = obj_dir/Vtb_core

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_core -f tb.f
	./$(SIM) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

//--- tb_core.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_core;

  localparam int timeout_cycles = 600;
  localparam core_pkg::addr_t entry_pc = 64'h1000;

  logic               clk;
  logic               reset;
  core_pkg::addr_t    entry;
  logic               stall;
  logic               redirect;
  core_pkg::addr_t    redirect_pc;
  logic               fetch_valid;
  core_pkg::instr_t   fetch_instr;
  core_pkg::addr_t    fetch_pc;
  logic               dreq;
  logic               dwe;
  core_pkg::addr_t    daddr;
  core_pkg::word_t    dwdata;
  core_pkg::word_t    drdata;
  logic               ddone;
  logic               bus_reqcyc;
  logic               bus_respack;
  core_pkg::word_t    bus_req;
  core_pkg::bus_tag_t bus_reqtag;
  logic               bus_respcyc;
  logic               bus_reqack;
  core_pkg::word_t    bus_resp;
  core_pkg::bus_tag_t bus_resptag;

  // bus side memory and the expected image keyed by doubleword address
  core_pkg::word_t mem [core_pkg::addr_t];
  core_pkg::word_t shadow [core_pkg::addr_t];

  logic [31:0]     lfsr;
  core_pkg::addr_t exp_pc;
  core_pkg::word_t expected;
  int              fetch_count;
  int              data_count;
  int              checks;
  int              mismatches;
  int              other_errors;
  string           test_name;

  core_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic core_pkg::addr_t dword_key(input core_pkg::addr_t a);
    return {a[63:3], 3'b000};
  endfunction

  // expected doubleword or instruction at a from the shadow image
  function automatic core_pkg::word_t ref_word(input core_pkg::addr_t a, input logic instr);
    core_pkg::word_t dw;
    if (!shadow.exists(dword_key(a))) begin
      return 'x;
    end
    dw = shadow[dword_key(a)];
    if (!instr) begin
      return dw;
    end
    return a[2] ? {32'd0, dw[63:32]} : {32'd0, dw[31:0]};
  endfunction

  task automatic preload(input core_pkg::addr_t base, input int n);
    core_pkg::word_t w;
    int              i;
    for (i = 0; i < n; i++) begin
      w = rand_bits(64);
      mem[base + core_pkg::addr_t'(i * 8)] = w;
      shadow[base + core_pkg::addr_t'(i * 8)] = w;
    end
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    mismatches++;
    $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
  endtask

  task automatic finish_run();
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  // the bus model waits 0 to 3 idle cycles before each ack or response beat
  task automatic bus_delay();
    int d;
    d = int'(rand_bits(2));
    repeat (d) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic write_line(input core_pkg::addr_t base);
    int i;
    for (i = 0; i < `CORE_BEATS; i++) begin
      bus_delay();
      if (!bus_reqcyc) begin
        other_errors++;
        $display("write beat %0d of line %h came without bus_reqcyc", i, base);
      end
      mem[base + core_pkg::addr_t'(i * 8)] = bus_req;
      bus_reqack = 1'b1;
      @(posedge clk);
      #1;
      bus_reqack = 1'b0;
    end
  endtask

  task automatic read_line(input core_pkg::addr_t base);
    core_pkg::addr_t a;
    int              i;
    for (i = 0; i < `CORE_BEATS; i++) begin
      bus_delay();
      a = base + core_pkg::addr_t'(i * 8);
      if (!mem.exists(a)) begin
        other_errors++;
        $display("bus read of unmapped address %h", a);
      end
      bus_resp    = mem.exists(a) ? mem[a] : '0;
      bus_resptag = `CORE_TAG_READ;
      bus_respcyc = 1'b1;
      @(negedge clk);
      if (!bus_respack) begin
        other_errors++;
        $display("read beat %0d of line %h was not acknowledged", i, base);
      end
      @(posedge clk);
      #1;
      bus_respcyc = 1'b0;
    end
  endtask

  initial begin : bus_model
    core_pkg::addr_t    line_addr;
    core_pkg::bus_tag_t tag;
    forever begin
      @(posedge clk);
      #1;
      if (!reset && bus_reqcyc) begin
        line_addr = bus_req;
        tag       = bus_reqtag;
        if (line_addr[5:0] != 6'd0) begin
          other_errors++;
          $display("bus request address %h is not line aligned", line_addr);
        end
        bus_delay();
        bus_reqack = 1'b1;
        @(posedge clk);
        #1;
        bus_reqack = 1'b0;
        if (tag == `CORE_TAG_WRITE) begin
          write_line(line_addr);
        end else if (tag == `CORE_TAG_READ) begin
          read_line(line_addr);
        end else begin
          other_errors++;
          $display("unknown bus tag %h", tag);
        end
      end
    end
  end

  // compare every fetch and data completion mid-cycle when outputs are settled
  always @(negedge clk) begin
    if (reset) begin
      if (fetch_valid || ddone || bus_reqcyc || bus_respack) begin
        other_errors++;
        $display("strobe seen during reset at %0t", $time);
      end
    end else begin
      if (fetch_valid) begin
        checks++;
        if (stall) begin
          other_errors++;
          $display("fetch_valid while stall is high at %0t", $time);
        end
        if (fetch_pc !== exp_pc) begin
          report_mismatch("fetch_pc", exp_pc, fetch_pc);
        end
        expected = ref_word(fetch_pc, 1'b1);
        if (fetch_instr !== expected[31:0]) begin
          report_mismatch("fetch_instr", expected, {32'd0, fetch_instr});
        end
        exp_pc = exp_pc + 64'd4;
        fetch_count++;
      end
      if (ddone) begin
        checks++;
        if (dwe) begin
          shadow[dword_key(daddr)] = dwdata;
        end else begin
          expected = ref_word(daddr, 1'b0);
          if (drdata !== expected) begin
            report_mismatch("load", expected, drdata);
          end
        end
        data_count++;
      end
    end
  end

  task automatic wait_fetches(input int n);
    int target;
    int t;
    target = fetch_count + n;
    t = 0;
    while (fetch_count < target && t < timeout_cycles) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (fetch_count < target) begin
      other_errors++;
      $display("timeout in %s waiting for %0d fetches", test_name, n);
    end
  endtask

  // hold the request until the checker has seen ddone
  task automatic data_access(input logic we, input core_pkg::addr_t a,
                             input core_pkg::word_t d);
    int target;
    int t;
    target = data_count + 1;
    dreq   = 1'b1;
    dwe    = we;
    daddr  = a;
    dwdata = d;
    t = 0;
    while (data_count < target && t < timeout_cycles) begin
      @(posedge clk);
      #1;
      t++;
    end
    dreq = 1'b0;
    if (data_count < target) begin
      other_errors++;
      $display("timeout in %s waiting for ddone at address %h", test_name, a);
    end
  endtask

  task automatic compare_memory();
    foreach (shadow[k]) begin
      checks++;
      if (!mem.exists(k)) begin
        other_errors++;
        $display("bus memory has no word at %h", k);
      end else if (mem[k] !== shadow[k]) begin
        report_mismatch("memory", shadow[k], mem[k]);
      end
    end
  endtask

  initial begin : stimulus
    core_pkg::addr_t a;
    logic [63:0]     r;
    int              i;
    int              held;
    reset        = 1'b1;
    entry        = entry_pc;
    stall        = 1'b0;
    redirect     = 1'b0;
    redirect_pc  = '0;
    dreq         = 1'b0;
    dwe          = 1'b0;
    daddr        = '0;
    dwdata       = '0;
    bus_respcyc  = 1'b0;
    bus_reqack   = 1'b0;
    bus_resp     = '0;
    bus_resptag  = '0;
    lfsr         = 32'h1812;
    exp_pc       = entry_pc;
    fetch_count  = 0;
    data_count   = 0;
    checks       = 0;
    mismatches   = 0;
    other_errors = 0;
    test_name    = "reset_entry";
    // program region and a data region four times the dcache size
    preload(64'h1000, 256);
    preload(64'h8000, 512);
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    wait_fetches(1);

    test_name = "sequential";
    wait_fetches(40);

    test_name   = "redirect";
    redirect    = 1'b1;
    redirect_pc = 64'h1304;
    exp_pc      = 64'h1304;
    @(posedge clk);
    #1;
    redirect = 1'b0;
    // the lookup at 64'h1304 starts at the next edge and misses
    @(posedge clk);
    #1;
    // this redirect lands while that miss is still in flight
    redirect    = 1'b1;
    redirect_pc = 64'h1404;
    exp_pc      = 64'h1404;
    @(posedge clk);
    #1;
    redirect = 1'b0;
    wait_fetches(8);

    test_name = "stall";
    stall     = 1'b1;
    held      = fetch_count;
    repeat (20) begin
      @(posedge clk);
      #1;
    end
    if (fetch_count != held) begin
      other_errors++;
      $display("instructions were delivered while stall was held");
    end
    stall = 1'b0;
    wait_fetches(4);

    // fetch stays stalled so it cannot run past the program region
    test_name = "store_load";
    stall     = 1'b1;
    for (i = 0; i < 16; i++) begin
      r = rand_bits(9);
      a = 64'h8000 + (r << 3);
      data_access(1'b1, a, rand_bits(64));
      data_access(1'b0, a, '0);
      r = rand_bits(9);
      data_access(1'b0, 64'h8000 + (r << 3), '0);
    end
    test_name = "memory_image";
    compare_memory();

    // same dcache index with another tag so the second load misses
    test_name = "contention";
    data_access(1'b0, 64'h8308, '0);
    fork
      begin
        // the fetch miss at 64'h1700 is under way when the data miss arrives
        repeat (2) begin
          @(posedge clk);
          #1;
        end
        data_access(1'b0, 64'h8f38, '0);
      end
      begin
        stall       = 1'b0;
        redirect    = 1'b1;
        redirect_pc = 64'h1700;
        exp_pc      = 64'h1700;
        @(posedge clk);
        #1;
        redirect = 1'b0;
        wait_fetches(4);
      end
    join
    stall = 1'b1;
    repeat (4) begin
      @(posedge clk);
      #1;
    end
    finish_run();
  end

endmodule

//--- core_top.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_top (
  input  logic               clk,
  input  logic               reset,
  input  core_pkg::addr_t    entry,
  // stand-ins for the ALU stall and the jump or flush path
  input  logic               stall,
  input  logic               redirect,
  input  core_pkg::addr_t    redirect_pc,
  output logic               fetch_valid,
  output core_pkg::instr_t   fetch_instr,
  output core_pkg::addr_t    fetch_pc,
  // doubleword load/store port
  input  logic               dreq,
  input  logic               dwe,
  input  core_pkg::addr_t    daddr,
  input  core_pkg::word_t    dwdata,
  output core_pkg::word_t    drdata,
  output logic               ddone,
  // system bus
  output logic               bus_reqcyc,
  output logic               bus_respack,
  output core_pkg::word_t    bus_req,
  output core_pkg::bus_tag_t bus_reqtag,
  input  logic               bus_respcyc,
  input  logic               bus_reqack,
  input  core_pkg::word_t    bus_resp,
  input  core_pkg::bus_tag_t bus_resptag
);

  core_pkg::addr_t pc;
  logic            fetch_en;
  logic            icache_done;
  core_pkg::word_t icache_word;

  logic            ic_mem_req;
  logic            ic_mem_wr_en;
  logic            ic_mem_done;
  core_pkg::addr_t ic_mem_address;
  core_pkg::line_t ic_mem_data_out;
  core_pkg::line_t ic_mem_data_in;

  logic            dc_mem_req;
  logic            dc_mem_wr_en;
  logic            dc_mem_done;
  core_pkg::addr_t dc_mem_address;
  core_pkg::line_t dc_mem_data_out;
  core_pkg::line_t dc_mem_data_in;

  logic            mc_req;
  logic            mc_wr_en;
  logic            mc_data_valid;
  core_pkg::addr_t mc_address;
  core_pkg::line_t mc_data_in;
  core_pkg::line_t mc_data_out;

  fetch_unit fetch (
    .clk(clk), .reset(reset), .entry(entry),
    .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
    .icache_done(icache_done), .icache_instr(icache_word[`CORE_INST_W-1:0]),
    .pc(pc), .fetch_en(fetch_en),
    .fetch_valid(fetch_valid), .fetch_instr(fetch_instr), .fetch_pc(fetch_pc)
  );

  cache icache (
    .clk(clk), .reset(reset), .enable(fetch_en), .wr_en(1'b0),
    .addr(pc), .data_in('0), .data_out(icache_word), .done(icache_done),
    .mem_req(ic_mem_req), .mem_wr_en(ic_mem_wr_en), .mem_address(ic_mem_address),
    .mem_data_out(ic_mem_data_out), .mem_data_in(ic_mem_data_in), .mem_done(ic_mem_done)
  );

  cache dcache (
    .clk(clk), .reset(reset), .enable(dreq), .wr_en(dwe),
    .addr(daddr), .data_in(dwdata), .data_out(drdata), .done(ddone),
    .mem_req(dc_mem_req), .mem_wr_en(dc_mem_wr_en), .mem_address(dc_mem_address),
    .mem_data_out(dc_mem_data_out), .mem_data_in(dc_mem_data_in), .mem_done(dc_mem_done)
  );

  arbiter arb (
    .clk(clk), .reset(reset),
    .icache_req(ic_mem_req), .icache_address(ic_mem_address),
    .icache_wr_en(ic_mem_wr_en), .icache_data_in(ic_mem_data_out),
    .icache_data_out(ic_mem_data_in), .icache_done(ic_mem_done),
    .dcache_req(dc_mem_req), .dcache_address(dc_mem_address),
    .dcache_wr_en(dc_mem_wr_en), .dcache_data_in(dc_mem_data_out),
    .dcache_data_out(dc_mem_data_in), .dcache_done(dc_mem_done),
    .mem_address(mc_address), .mem_data_out(mc_data_in),
    .mem_req(mc_req), .mem_wr_en(mc_wr_en),
    .data_from_mem(mc_data_out), .mem_data_valid(mc_data_valid)
  );

  memory_controller mc (
    .clk(clk), .reset(reset),
    .in_address(mc_address), .data_in(mc_data_in),
    .start_req(mc_req), .wr_en(mc_wr_en),
    .data_out(mc_data_out), .data_valid(mc_data_valid),
    .bus_reqcyc(bus_reqcyc), .bus_respack(bus_respack),
    .bus_req(bus_req), .bus_reqtag(bus_reqtag),
    .bus_respcyc(bus_respcyc), .bus_reqack(bus_reqack),
    .bus_resp(bus_resp), .bus_resptag(bus_resptag)
  );

endmodule

//--- memory_controller.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module memory_controller (
  input  logic               clk,
  input  logic               reset,
  input  core_pkg::addr_t    in_address,
  input  core_pkg::line_t    data_in,
  input  logic               start_req,
  input  logic               wr_en,
  output core_pkg::line_t    data_out,
  output logic               data_valid,
  // system bus
  output logic               bus_reqcyc,
  output logic               bus_respack,
  output core_pkg::word_t    bus_req,
  output core_pkg::bus_tag_t bus_reqtag,
  input  logic               bus_respcyc,
  input  logic               bus_reqack,
  input  core_pkg::word_t    bus_resp,
  input  core_pkg::bus_tag_t bus_resptag
);

  localparam int cnt_w = $clog2(`CORE_BEATS);

  core_pkg::mc_state_e state;
  core_pkg::addr_t     addr_r;
  logic                wr_r;
  logic [cnt_w-1:0]    beat;
  // outgoing line for writes, incoming line for reads
  core_pkg::line_t     shift;

  logic start;
  logic last_beat;
  logic send_beat;
  logic take_beat;

  // the requester still holds start_req during the data_valid cycle
  assign start     = (state == core_pkg::mc_idle) && start_req && !data_valid;
  assign last_beat = (beat == cnt_w'(`CORE_BEATS - 1));
  assign send_beat = (state == core_pkg::mc_write_beats) && bus_reqack;
  assign take_beat = (state == core_pkg::mc_read_beats) && bus_respcyc &&
                     (bus_resptag == `CORE_TAG_READ);

  assign bus_reqcyc  = (state == core_pkg::mc_req_addr) ||
                       (state == core_pkg::mc_write_beats);
  assign bus_req     = (state == core_pkg::mc_req_addr) ? addr_r :
                       shift[`CORE_WORD_W-1:0];
  assign bus_reqtag  = wr_r ? `CORE_TAG_WRITE : `CORE_TAG_READ;
  assign bus_respack = take_beat;
  assign data_out    = shift;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= core_pkg::mc_idle;
      wr_r       <= 1'b0;
      beat       <= '0;
      data_valid <= 1'b0;
    end else begin
      data_valid <= 1'b0;
      case (state)
        core_pkg::mc_idle: begin
          if (start) begin
            wr_r  <= wr_en;
            beat  <= '0;
            state <= core_pkg::mc_req_addr;
          end
        end
        core_pkg::mc_req_addr: begin
          if (bus_reqack) begin
            state <= wr_r ? core_pkg::mc_write_beats : core_pkg::mc_read_beats;
          end
        end
        core_pkg::mc_write_beats,
        core_pkg::mc_read_beats: begin
          if (send_beat || take_beat) begin
            beat <= beat + 1'b1;
            if (last_beat) begin
              data_valid <= 1'b1;
              state      <= core_pkg::mc_idle;
            end
          end
        end
        default: state <= core_pkg::mc_idle;
      endcase
    end
  end

  // lowest doubleword goes out first and comes back first
  always_ff @(posedge clk) begin
    if (start) begin
      addr_r <= in_address;
      shift  <= data_in;
    end else if (send_beat) begin
      shift <= shift >> `CORE_WORD_W;
    end else if (take_beat) begin
      shift <= {bus_resp, shift[`CORE_LINE_W-1:`CORE_WORD_W]};
    end
  end

endmodule

//--- arbiter.sv
`timescale 1ns/1ps

module arbiter (
  input  logic            clk,
  input  logic            reset,
  // instruction cache side
  input  logic            icache_req,
  input  core_pkg::addr_t icache_address,
  input  logic            icache_wr_en,
  input  core_pkg::line_t icache_data_in,
  output core_pkg::line_t icache_data_out,
  output logic            icache_done,
  // data cache side
  input  logic            dcache_req,
  input  core_pkg::addr_t dcache_address,
  input  logic            dcache_wr_en,
  input  core_pkg::line_t dcache_data_in,
  output core_pkg::line_t dcache_data_out,
  output logic            dcache_done,
  // memory controller side
  output core_pkg::addr_t mem_address,
  output core_pkg::line_t mem_data_out,
  output logic            mem_req,
  output logic            mem_wr_en,
  input  core_pkg::line_t data_from_mem,
  input  logic            mem_data_valid
);

  core_pkg::arb_state_e state;
  logic                 serve_d;

  assign serve_d = (state == core_pkg::arb_serve_d);

  // the granted cache holds its fields until done, so they pass straight through
  assign mem_req      = (state != core_pkg::arb_idle);
  assign mem_address  = serve_d ? dcache_address : icache_address;
  assign mem_data_out = serve_d ? dcache_data_in : icache_data_in;
  assign mem_wr_en    = serve_d ? dcache_wr_en :
                        (state == core_pkg::arb_serve_i) && icache_wr_en;

  assign icache_done     = (state == core_pkg::arb_serve_i) && mem_data_valid;
  assign dcache_done     = serve_d && mem_data_valid;
  assign icache_data_out = data_from_mem;
  assign dcache_data_out = data_from_mem;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= core_pkg::arb_idle;
    end else begin
      case (state)
        // data side first when both ask
        core_pkg::arb_idle: begin
          if (dcache_req) begin
            state <= core_pkg::arb_serve_d;
          end else if (icache_req) begin
            state <= core_pkg::arb_serve_i;
          end
        end
        core_pkg::arb_serve_i,
        core_pkg::arb_serve_d: begin
          if (mem_data_valid) begin
            state <= core_pkg::arb_idle;
          end
        end
        default: state <= core_pkg::arb_idle;
      endcase
    end
  end

endmodule

//--- cache.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module cache (
  input  logic            clk,
  input  logic            reset,
  input  logic            enable,
  input  logic            wr_en,
  input  core_pkg::addr_t addr,
  input  core_pkg::word_t data_in,
  output core_pkg::word_t data_out,
  output logic            done,
  output logic            mem_req,
  output logic            mem_wr_en,
  output core_pkg::addr_t mem_address,
  output core_pkg::line_t mem_data_out,
  input  core_pkg::line_t mem_data_in,
  input  logic            mem_done
);

  localparam int lines_n = 1 << `CORE_INDEX_W;
  localparam int off_w   = $clog2(`CORE_LINE_W / 8);
  localparam int byte_w  = $clog2(`CORE_WORD_W / 8);
  localparam int sel_w   = off_w - byte_w;
  localparam int tag_w   = `CORE_WORD_W - `CORE_INDEX_W - off_w;

  core_pkg::cache_state_e state;

  // request captured when leaving idle
  core_pkg::addr_t req_addr;
  logic            req_wr;
  core_pkg::word_t req_data;

  core_pkg::line_t    lines [lines_n];
  logic [tag_w-1:0]   tags [lines_n];
  logic [lines_n-1:0] valid;

  logic [`CORE_INDEX_W-1:0] idx;
  logic [tag_w-1:0]         tag;
  logic [sel_w-1:0]         sel;
  logic                     hit;
  core_pkg::line_t          cur_line;
  core_pkg::line_t          merged;
  core_pkg::word_t          cur_word;

  assign idx      = req_addr[off_w +: `CORE_INDEX_W];
  assign tag      = req_addr[`CORE_WORD_W-1 -: tag_w];
  assign sel      = req_addr[off_w-1:byte_w];
  assign cur_line = lines[idx];
  assign hit      = valid[idx] && (tags[idx] == tag);
  assign cur_word = cur_line[sel*`CORE_WORD_W +: `CORE_WORD_W];

  // store data replaces one doubleword of the resident line
  always_comb begin
    merged = cur_line;
    merged[sel*`CORE_WORD_W +: `CORE_WORD_W] = req_data;
  end

  // bit 2 picks the upper instruction of the doubleword
  assign data_out = req_addr[2] ?
                    {{(`CORE_WORD_W - `CORE_INST_W){1'b0}},
                     cur_word[`CORE_WORD_W-1 -: `CORE_INST_W]} :
                    cur_word;

  assign done = (state == core_pkg::cache_lookup && hit && !req_wr) ||
                (state == core_pkg::cache_write_through && mem_done);

  assign mem_req      = (state == core_pkg::cache_refill) ||
                        (state == core_pkg::cache_write_through);
  assign mem_wr_en    = (state == core_pkg::cache_write_through);
  assign mem_address  = {req_addr[`CORE_WORD_W-1:off_w], {off_w{1'b0}}};
  assign mem_data_out = cur_line;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= core_pkg::cache_idle;
    end else begin
      case (state)
        core_pkg::cache_idle: begin
          if (enable) begin
            state <= core_pkg::cache_lookup;
          end
        end
        core_pkg::cache_lookup: begin
          if (!hit) begin
            state <= core_pkg::cache_refill;
          end else if (req_wr) begin
            state <= core_pkg::cache_write_through;
          end else begin
            state <= core_pkg::cache_idle;
          end
        end
        // look up again once the line is in, a store then merges on the hit
        core_pkg::cache_refill: begin
          if (mem_done) begin
            state <= core_pkg::cache_lookup;
          end
        end
        core_pkg::cache_write_through: begin
          if (mem_done) begin
            state <= core_pkg::cache_idle;
          end
        end
        default: state <= core_pkg::cache_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == core_pkg::cache_idle && enable) begin
      req_addr <= addr;
      req_wr   <= wr_en;
      req_data <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (state == core_pkg::cache_refill && mem_done) begin
      lines[idx] <= mem_data_in;
      tags[idx]  <= tag;
    end else if (state == core_pkg::cache_lookup && hit && req_wr) begin
      lines[idx] <= merged;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (state == core_pkg::cache_refill && mem_done) begin
      valid[idx] <= 1'b1;
    end
  end

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic             clk,
  input  logic             reset,
  input  core_pkg::addr_t  entry,
  input  logic             stall,
  input  logic             redirect,
  input  core_pkg::addr_t  redirect_pc,
  input  logic             icache_done,
  input  core_pkg::instr_t icache_instr,
  output core_pkg::addr_t  pc,
  output logic             fetch_en,
  output logic             fetch_valid,
  output core_pkg::instr_t fetch_instr,
  output core_pkg::addr_t  fetch_pc
);

  // an icache lookup is in flight, mirrors the cache leaving idle
  logic pending;
  // the lookup in flight was issued on a path that has since been redirected
  logic discard;
  logic accept;

  // no new lookup while stalled or while the pc is being redirected
  assign fetch_en = !stall && !redirect;

  // keep a word only if it is on the current path and fetch is not held
  assign accept      = icache_done && !discard && !redirect && !stall;
  assign fetch_valid = accept;
  assign fetch_instr = icache_instr;
  assign fetch_pc    = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= entry;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (accept) begin
      pc <= pc + core_pkg::addr_t'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
      discard <= 1'b0;
    end else if (icache_done) begin
      pending <= 1'b0;
      discard <= 1'b0;
    end else begin
      if (fetch_en) begin
        pending <= 1'b1;
      end
      // the old-path word still arrives later and must be thrown away
      if (redirect && pending) begin
        discard <= 1'b1;
      end
    end
  end

endmodule

//--- core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

  typedef logic [`CORE_WORD_W-1:0] addr_t;
  typedef logic [`CORE_WORD_W-1:0] word_t;
  typedef logic [`CORE_INST_W-1:0] instr_t;
  typedef logic [`CORE_LINE_W-1:0] line_t;
  typedef logic [`CORE_BUS_TAG_W-1:0] bus_tag_t;

  typedef enum logic [1:0] {
    cache_idle,
    cache_lookup,
    cache_refill,
    cache_write_through
  } cache_state_e;

  typedef enum logic [1:0] {
    arb_idle,
    arb_serve_i,
    arb_serve_d
  } arb_state_e;

  typedef enum logic [1:0] {
    mc_idle,
    mc_req_addr,
    mc_write_beats,
    mc_read_beats
  } mc_state_e;

endpackage

//--- core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data word and byte address width
`define CORE_WORD_W 64

// instruction width
`define CORE_INST_W 32

// one cache line, moved over the bus as CORE_BEATS doublewords
`define CORE_LINE_W 512
`define CORE_BEATS 8

// cache index bits, 16 lines per cache
`define CORE_INDEX_W 4

`define CORE_BUS_TAG_W 13

// bus tags: bit 12 marks a read, bits 11:8 select the memory device
`define CORE_TAG_READ 13'h1100
`define CORE_TAG_WRITE 13'h0100

`endif
